// File: fetch_buffer.f
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_buffer_ram.sv
hw/fetch_buffer_ctrl.sv
hw/fetch_buffer.sv
verification/fetch_buffer_props.sv
verification/fetch_buffer_tb.sv

// File: hw/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::fetch_req_t fetch_in,
  output fetch_pkg::fetch_rsp_t fetch_out,
  input  fetch_pkg::imem_rsp_t  imem_in,
  output fetch_pkg::imem_req_t  imem_out
);

  fetch_pkg::ram_wr_t ram_wr;
  fetch_pkg::ram_rd_t ram_rd;

  fetch_buffer_ram ram_i (
    .clock   (clock),
    .ram_in  (ram_wr),
    .ram_out (ram_rd)
  );

  fetch_buffer_ctrl ctrl_i (
    .clock     (clock),
    .reset     (reset),
    .fetch_in  (fetch_in),
    .fetch_out (fetch_out),
    .imem_in   (imem_in),
    .imem_out  (imem_out),
    .ram_out   (ram_wr),
    .ram_in    (ram_rd)
  );

endmodule

`default_nettype wire

// File: hw/fetch_buffer_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defines.svh"

module fetch_buffer_ctrl (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::fetch_req_t fetch_in,
  output fetch_pkg::fetch_rsp_t fetch_out,
  input  fetch_pkg::imem_rsp_t  imem_in,
  output fetch_pkg::imem_req_t  imem_out,
  output fetch_pkg::ram_wr_t    ram_out,
  input  fetch_pkg::ram_rd_t    ram_in
);

  localparam int index_w = `FETCH_INDEX_W;
  localparam int count_w = index_w + 2;
  localparam logic [count_w-1:0] fill_limit = count_w'(`FETCH_LIMIT);

  localparam logic [1:0] st_idle     = 2'd0;
  localparam logic [1:0] st_stream   = 2'd1;
  localparam logic [1:0] st_redirect = 2'd2;

  logic [1:0]              state_q;
  logic [1:0]              state_d;
  logic [`FETCH_DEPTH-1:0] valid_q;
  logic [`FETCH_DEPTH-1:0] valid_d;
  logic [31:0]             pf_addr_q;
  logic [31:0]             pf_addr_d;
  logic [31:0]             redir_addr_q;
  logic [31:0]             redir_addr_d;
  logic [count_w-1:0]      count_q;
  logic [count_w-1:0]      count_d;
  logic [count_w-1:0]      count_inc;
  logic                    pend_q;

  logic                     flush;
  logic                     take;
  logic                     wr_en;
  logic [index_w-1:0]       wr_idx;
  logic [index_w-1:0]       rd_idx1;
  logic [index_w-1:0]       rd_idx2;
  logic [31:0]              addr_next;
  logic [29:0]              tag1;
  logic [29:0]              tag2;
  fetch_pkg::buffer_entry_t wr_entry;
  fetch_pkg::buffer_entry_t entry1;
  fetch_pkg::buffer_entry_t entry2;
  logic                     avail1;
  logic                     avail2;
  logic [31:0]              rdata;
  logic                     error;
  logic                     ready;
  logic [1:0]               step;

  // a redirect request is taken in one cycle and returns no data.
  assign flush = fetch_in.valid & fetch_in.redirect;
  assign take  = fetch_in.valid & ~fetch_in.redirect & (state_q == st_stream);

  // responses during a redirect are dropped.
  assign wr_en  = imem_in.ready & (state_q == st_stream) & ~flush;
  assign wr_idx = pf_addr_q[index_w+1:2];

  assign wr_entry.tag       = pf_addr_q[31:2];
  assign wr_entry.error     = imem_in.error;
  assign wr_entry.data.word = imem_in.rdata;

  assign addr_next = fetch_in.addr + 32'd4;
  assign rd_idx1   = fetch_in.addr[index_w+1:2];
  assign rd_idx2   = addr_next[index_w+1:2];
  assign tag1      = fetch_in.addr[31:2];
  assign tag2      = addr_next[31:2];

  assign ram_out.wen    = wr_en;
  assign ram_out.waddr  = wr_idx;
  assign ram_out.raddr1 = rd_idx1;
  assign ram_out.raddr2 = rd_idx2;
  assign ram_out.wdata  = wr_entry;

  // hit detection, with bypass of the word arriving this cycle.
  always_comb begin
    entry1 = ram_in.rdata1;
    avail1 = valid_q[rd_idx1] && (ram_in.rdata1.tag == tag1);
    if (wr_en && (wr_entry.tag == tag1)) begin
      entry1 = wr_entry;
      avail1 = 1'b1;
    end
    entry2 = ram_in.rdata2;
    avail2 = valid_q[rd_idx2] && (ram_in.rdata2.tag == tag2);
    if (wr_en && (wr_entry.tag == tag2)) begin
      entry2 = wr_entry;
      avail2 = 1'b1;
    end
  end

  // instruction assembly; low bits 2'b11 mark a 32-bit instruction.
  always_comb begin
    rdata = 32'h0;
    error = 1'b0;
    ready = 1'b0;
    step  = 2'd0;
    if (!fetch_in.addr[1]) begin
      if (entry1.data.half.lo[1:0] != 2'b11) begin
        rdata = {16'h0, entry1.data.half.lo};  // compressed.
        step  = 2'd1;
      end else begin
        rdata = entry1.data.word;
        step  = 2'd2;
      end
      error = entry1.error;
      ready = take & avail1;
    end else if (entry1.data.half.hi[1:0] != 2'b11) begin
      rdata = {16'h0, entry1.data.half.hi};  // compressed, upper half.
      error = entry1.error;
      step  = 2'd1;
      ready = take & avail1;
    end else begin
      // split instruction, error from the second word.
      rdata = {entry2.data.half.lo, entry1.data.half.hi};
      error = entry2.error;
      step  = 2'd2;
      ready = take & avail1 & avail2;
    end
  end

  assign fetch_out.ready = ready;
  assign fetch_out.error = error;
  assign fetch_out.rdata = rdata;

  // the outstanding request is held through a redirect.
  always_comb begin
    case (state_q)
      st_stream:   imem_out.valid = (count_q < fill_limit);
      st_redirect: imem_out.valid = pend_q;
      default:     imem_out.valid = 1'b0;
    endcase
  end

  assign imem_out.addr = pf_addr_q;

  always_comb begin
    state_d      = state_q;
    valid_d      = valid_q;
    pf_addr_d    = pf_addr_q;
    redir_addr_d = redir_addr_q;
    count_inc    = count_q + (wr_en ? count_w'(2) : count_w'(0));
    count_d      = count_inc;
    if (ready && (count_w'(step) <= count_inc)) begin
      count_d = count_inc - count_w'(step);
    end
    case (state_q)
      st_idle: begin
        state_d = st_stream;
      end
      st_stream: begin
        if (wr_en) begin
          valid_d[wr_idx] = 1'b1;
          pf_addr_d       = pf_addr_q + 32'd4;
        end
      end
      st_redirect: begin
        // drained or nothing in flight.
        if (imem_in.ready || !pend_q) begin
          state_d   = st_stream;
          pf_addr_d = {redir_addr_q[31:2], 2'b00};
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
    if (flush) begin
      state_d      = st_redirect;
      redir_addr_d = fetch_in.addr;
      valid_d      = '0;
      count_d      = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q      <= st_idle;
      valid_q      <= '0;
      pf_addr_q    <= '0;
      redir_addr_q <= '0;
      count_q      <= '0;
      pend_q       <= 1'b0;
    end else begin
      state_q      <= state_d;
      valid_q      <= valid_d;
      pf_addr_q    <= pf_addr_d;
      redir_addr_q <= redir_addr_d;
      count_q      <= count_d;
      pend_q       <= imem_out.valid & ~imem_in.ready;  // request in flight.
    end
  end

endmodule

`default_nettype wire

// File: hw/fetch_buffer_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defines.svh"

module fetch_buffer_ram (
  input  logic               clock,
  input  fetch_pkg::ram_wr_t ram_in,
  output fetch_pkg::ram_rd_t ram_out
);

  fetch_pkg::buffer_entry_t mem [`FETCH_DEPTH];

  // word holding the instruction start.
  assign ram_out.rdata1 = mem[ram_in.raddr1];
  // following word, for split instructions.
  assign ram_out.rdata2 = mem[ram_in.raddr2];

  always_ff @(posedge clock) begin
    if (ram_in.wen) begin
      mem[ram_in.waddr] <= ram_in.wdata;
    end
  end

endmodule

`default_nettype wire

// File: hw/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// number of buffer words, a power of two.
`define FETCH_DEPTH 8

// width of a buffer index.
`define FETCH_INDEX_W $clog2(`FETCH_DEPTH)

// halfword count that stops prefetch.
// two halfwords short of full, so the word being read is never overwritten.
`define FETCH_LIMIT (2 * `FETCH_DEPTH - 2)

`endif

// File: hw/fetch_pkg.sv
`default_nettype none
`include "fetch_defines.svh"

package fetch_pkg;

  typedef struct packed {
    logic        valid;
    logic        redirect;  // branch target or fence.
    logic [31:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } fetch_rsp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } imem_rsp_t;

  // one instruction word, whole or as two halfwords.
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
    } half;
  } fetch_word_u;

  typedef struct packed {
    logic [29:0] tag;  // address bits 31:2.
    logic        error;
    fetch_word_u data;
  } buffer_entry_t;

  typedef struct packed {
    logic                      wen;
    logic [`FETCH_INDEX_W-1:0] waddr;
    logic [`FETCH_INDEX_W-1:0] raddr1;
    logic [`FETCH_INDEX_W-1:0] raddr2;
    buffer_entry_t             wdata;
  } ram_wr_t;

  typedef struct packed {
    buffer_entry_t rdata1;
    buffer_entry_t rdata2;
  } ram_rd_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f fetch_buffer.f \
  --top-module fetch_buffer_tb -o sim_fetch_buffer
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_fetch_buffer)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

// File: verification/fetch_buffer_props.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer_props (
  input logic                  clock,
  input logic                  reset,
  input fetch_pkg::fetch_req_t fetch_in,
  input fetch_pkg::fetch_rsp_t fetch_out,
  input fetch_pkg::imem_rsp_t  imem_in,
  input fetch_pkg::imem_req_t  imem_out
);

  // core sees ready only for a pending request.
  ready_needs_valid: assert property (@(posedge clock) disable iff (!reset)
    fetch_out.ready |-> fetch_in.valid)
    else $error("fetch ready raised without fetch valid");

  // memory request held until the response.
  imem_addr_stable: assert property (@(posedge clock) disable iff (!reset)
    (imem_out.valid && !imem_in.ready) |=> (imem_out.valid && $stable(imem_out.addr)))
    else $error("imem valid or addr changed while waiting for ready");

  quiet_in_reset: assert property (@(posedge clock)
    !reset |-> (!fetch_out.ready && !imem_out.valid))
    else $error("fetch ready or imem valid high during reset");

endmodule

bind fetch_buffer fetch_buffer_props props_i (.*);

`default_nettype wire

// File: verification/fetch_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer_tb;

  localparam int num_requests = 140;
  localparam int limit_cycles = num_requests * 40 + 40;

  logic                  clock;
  logic                  reset;
  fetch_pkg::fetch_req_t fetch_req;
  fetch_pkg::fetch_rsp_t fetch_rsp;
  fetch_pkg::imem_req_t  imem_req;
  fetch_pkg::imem_rsp_t  imem_rsp;

  logic [31:0] mem [64];
  logic [31:0] lfsr;
  logic [1:0]  wait_cnt;
  int          checks;
  int          errors;
  int          test_errors;
  int          imem_cycles;

  fetch_buffer dut_i (
    .clock     (clock),
    .reset     (reset),
    .fetch_in  (fetch_req),
    .fetch_out (fetch_rsp),
    .imem_in   (imem_rsp),
    .imem_out  (imem_req)
  );

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // expected instruction at a halfword address.
  function automatic void expect_instr(input logic [31:0] a, output logic [31:0] d,
                                       output logic e, output int len);
    logic [5:0]  w;
    logic [5:0]  w1;
    logic [15:0] first;
    w     = a[7:2];
    w1    = w + 6'd1;
    first = a[1] ? mem[w][31:16] : mem[w][15:0];
    e     = (w >= 6'd48);
    if (first[1:0] != 2'b11) begin
      d   = {16'h0, first};
      len = 1;
    end else if (!a[1]) begin
      d   = mem[w];
      len = 2;
    end else begin
      d   = {mem[w1][15:0], first};  // split across two words.
      e   = (w1 >= 6'd48);
      len = 2;
    end
  endfunction

  task automatic fetch_check(input logic [31:0] a, output int len);
    logic [31:0] exp_data;
    logic        exp_err;
    expect_instr(a, exp_data, exp_err, len);
    fetch_req.valid    = 1'b1;
    fetch_req.redirect = 1'b0;
    fetch_req.addr     = a;
    @(negedge clock);
    while (!fetch_rsp.ready) @(negedge clock);
    checks++;
    assert (fetch_rsp.rdata == exp_data) else begin
      errors++;
      $display("mismatch at %0t: addr %h rdata %h expected %h", $time, a,
               fetch_rsp.rdata, exp_data);
    end
    assert (fetch_rsp.error == exp_err) else begin
      errors++;
      $display("mismatch at %0t: addr %h error %b expected %b", $time, a,
               fetch_rsp.error, exp_err);
    end
    @(posedge clock);
    #1;
    fetch_req.valid = 1'b0;
  endtask

  task automatic redirect_to(input logic [31:0] a);
    fetch_req.valid    = 1'b1;
    fetch_req.redirect = 1'b1;
    fetch_req.addr     = a;
    @(posedge clock);
    #1;
    fetch_req.valid    = 1'b0;
    fetch_req.redirect = 1'b0;
  endtask

  task automatic walk(input logic [31:0] start, input int n, output logic [31:0] last);
    int len;
    last = start;
    repeat (n) begin
      fetch_check(last, len);
      last = last + 32'(2 * len);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s finished with %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // memory model, 1 to 3 cycles per word.
  initial begin
    wait_cnt = 2'd0;
    imem_rsp = '0;
    forever begin
      @(posedge clock);
      #1;
      imem_rsp.ready = 1'b0;
      if (reset && imem_req.valid) begin
        imem_cycles++;
        if (wait_cnt == 2'd0) begin
          wait_cnt = 2'(draw_bits(2) % 3) + 2'd1;
        end
        wait_cnt = wait_cnt - 2'd1;
        if (wait_cnt == 2'd0) begin
          imem_rsp.ready = 1'b1;
          imem_rsp.rdata = mem[imem_req.addr[7:2]];
          imem_rsp.error = (imem_req.addr[7:2] >= 6'd48);
        end
      end
    end
  end

  initial begin
    repeat (limit_cycles) @(posedge clock);
    $display("timeout: the DUT stopped answering fetch requests");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [31:0] a;
    logic [5:0]  offsets [2];
    int          len;
    int          busy_before;
    fetch_req   = '0;
    reset       = 1'b0;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    imem_cycles = 0;
    lfsr        = 32'he3dc_cadc;
    for (int i = 0; i < 64; i++) begin
      mem[i] = draw_bits(32);
    end
    for (int i = 0; i < 2; i++) begin
      offsets[i] = 6'(draw_bits(6));  // redirect targets.
    end

    repeat (8) begin
      @(negedge clock);
      checks++;
      assert (!fetch_rsp.ready && !imem_req.valid) else begin
        errors++;
        $display("handshake active during reset at %0t", $time);
      end
    end
    @(posedge clock);
    #1;
    reset = 1'b1;
    @(negedge clock);
    checks++;
    assert (!fetch_rsp.ready && !imem_req.valid) else begin
      errors++;
      $display("handshake active in the first cycle after reset at %0t", $time);
    end
    @(posedge clock);
    #1;
    end_test("reset");

    for (int k = 0; k < 16; k++) begin
      fetch_check(32'(4 * k), len);
      if (len == 1) begin
        redirect_to(32'(4 * k + 4));  // skipped halfword would stay counted.
      end
    end
    end_test("aligned");

    redirect_to(32'h0);
    walk(32'h0, 24, a);
    end_test("walk");

    for (int r = 0; r < 2; r++) begin
      a = {25'h0, offsets[r], 1'b0};
      redirect_to(a);
      walk(a, 8, a);
    end
    end_test("redirect");

    redirect_to(32'hb0);
    walk(32'hb0, 20, a);
    end_test("error");

    redirect_to(32'h40);
    walk(32'h40, 4, a);
    repeat (40) @(posedge clock);
    @(negedge clock);
    checks++;
    assert (!imem_req.valid) else begin
      errors++;
      $display("prefetch still running with the buffer full at %0t", $time);
    end
    @(posedge clock);
    #1;
    busy_before = imem_cycles;
    walk(a, 12, a);
    checks++;
    assert (imem_cycles > busy_before) else begin
      errors++;
      $display("prefetch did not restart after the core resumed");
    end
    end_test("backpressure");

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
